//--- verilog/rv_pkg.sv
/* rv_pkg
 * types and constants shared by every stage of the rv32i pipeline
 */
`default_nettype none

package rv_pkg;

    localparam int XLEN       = 32;                 // data and address width
    localparam int REG_ADDR_W = 5;                  // 32 architectural registers

    localparam logic [XLEN-1:0] INSTR_BYTES = 4;    // pc step, no compressed set

    // base opcodes of the supported subset
    localparam logic [6:0] OPC_OP     = 7'b0110011; // add sub and or xor slt
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011; // only addi is kept
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_LOAD   = 7'b0000011; // lw only
    localparam logic [6:0] OPC_STORE  = 7'b0100011; // sw only
    localparam logic [6:0] OPC_BRANCH = 7'b1100011; // beq and bne
    localparam logic [6:0] OPC_JAL    = 7'b1101111;

    // class of a decoded instruction, picks the path through execute and retire
    typedef enum logic [2:0] {
        op_alu,
        op_load,
        op_store,
        op_branch,
        op_jump,
        op_nop                                      // unsupported encodings land here
    } op_type;

    typedef enum logic [2:0] {
        alu_add,
        alu_sub,
        alu_and,
        alu_or,
        alu_xor,
        alu_slt,
        alu_pass_b                                  // lui, immediate straight through
    } alu_op;

    typedef enum logic [1:0] {
        br_eq,
        br_ne,
        br_always                                   // jal
    } br_cond;

    typedef logic [3:0] tag_t;                      // counts redirects, wraps freely

endpackage

`default_nettype wire

//--- verilog/pipe_if.sv
/* pipeline bundles
 * decode to execute and execute to retire stage registers
 */
`timescale 1ns/100ps
`default_nettype none

interface dec_exe_if import rv_pkg::*; ();
    logic [XLEN-1:0]       npc;         // pc + 4 of the instruction
    logic [XLEN-1:0]       op_a;        // rs1 value
    logic [XLEN-1:0]       op_b;        // immediate or rs2, by format
    logic [XLEN-1:0]       store_data;  // rs2 value, also the branch compare operand
    op_type                op;
    alu_op                 alu;
    br_cond                cond;
    logic [REG_ADDR_W-1:0] rd;          // zero when nothing is written back
    tag_t                  tag;
    logic                  valid;       // low for bubbles

    modport master (output npc, op_a, op_b, store_data, op, alu, cond, rd, tag, valid);
    modport slave  (input  npc, op_a, op_b, store_data, op, alu, cond, rd, tag, valid);
endinterface

interface exe_ret_if import rv_pkg::*; ();
    logic [XLEN-1:0]       result;      // alu value, memory address or link address
    logic [XLEN-1:0]       target;      // branch or jal destination
    logic                  jump;        // redirect requested
    op_type                op;
    logic [REG_ADDR_W-1:0] rd;
    logic [XLEN-1:0]       store_data;
    tag_t                  tag;
    logic                  valid;

    modport master (output result, target, jump, op, rd, store_data, tag, valid);
    modport slave  (input  result, target, jump, op, rd, store_data, tag, valid);
endinterface

`default_nettype wire

//--- verilog/fetch.sv
/* fetch
 * program counter with jump redirect, stall and hazard hold, and tag count
 */
`timescale 1ns/100ps
`default_nettype none

module fetch import rv_pkg::*; #(
    parameter logic [XLEN-1:0] RESET_PC = '0    // address of the first instruction
) (
    input  logic            clk,
    input  logic            i_reset,
    input  logic            i_stall,            // freezes pc and tag
    input  logic            i_hazard,           // decode waits on an operand
    input  logic            i_jump,             // one-cycle redirect from retire
    input  logic [XLEN-1:0] i_new_pc,
    output logic [XLEN-1:0] o_pc,               // instruction address
    output logic [XLEN-1:0] o_npc,              // always o_pc + 4
    output tag_t            o_tag
);

    logic [XLEN-1:0] pc_next;

    always_comb begin
        if (i_jump)
            pc_next = i_new_pc;                 // redirect wins over a hazard hold
        else if (i_hazard)
            pc_next = o_pc;                     // present the same instruction again
        else
            pc_next = o_pc + INSTR_BYTES;
    end

    always_ff @(posedge clk) begin
        if (i_reset) begin
            o_pc  <= RESET_PC;
            o_npc <= RESET_PC + INSTR_BYTES;
            o_tag <= '0;
        end else if (!i_stall) begin
            o_pc  <= pc_next;
            o_npc <= pc_next + INSTR_BYTES;     // registered next to the pc
            if (i_jump)
                o_tag <= o_tag + 4'd1;          // the two younger ones keep the old tag
        end
    end

endmodule

`default_nettype wire

//--- verilog/decoder.sv
/* decoder
 * field split, classification, immediates, operand select and hazard detect
 */
`timescale 1ns/100ps
`default_nettype none

module decoder import rv_pkg::*; (
    input  logic                  clk,
    input  logic                  i_reset,
    input  logic                  i_stall,
    input  logic [XLEN-1:0]       i_instruction,    // combinational from memory
    input  logic [XLEN-1:0]       i_npc,
    input  tag_t                  i_tag,
    output logic [REG_ADDR_W-1:0] o_reg_a,          // rs1 to regbank
    output logic [REG_ADDR_W-1:0] o_reg_b,          // rs2 to regbank
    input  logic [XLEN-1:0]       i_data_a,
    input  logic [XLEN-1:0]       i_data_b,
    input  logic [REG_ADDR_W-1:0] i_exe_rd,         // destination now in execute
    input  logic                  i_exe_valid,
    input  logic [REG_ADDR_W-1:0] i_ret_rd,         // destination now in retire
    input  logic                  i_ret_valid,
    output logic                  o_hazard,
    dec_exe_if.master             o_dx
);

    logic [6:0]            opcode;
    logic [2:0]            funct3;
    logic [XLEN-1:0]       imm_i, imm_s, imm_b, imm_u, imm_j;
    logic [XLEN-1:0]       imm;
    op_type                op;
    alu_op                 alu;
    br_cond                cond;
    logic                  use_imm;                 // operand b from the immediate
    logic                  use_a, use_b;            // which sources are really read
    logic [REG_ADDR_W-1:0] rd;
    logic                  raw_a, raw_b, mem_hz;

    assign opcode  = i_instruction[6:0];
    assign funct3  = i_instruction[14:12];
    assign o_reg_a = i_instruction[19:15];
    assign o_reg_b = i_instruction[24:20];

    // immediates of every format, sign from bit 31
    assign imm_i = {{20{i_instruction[31]}}, i_instruction[31:20]};
    assign imm_s = {{20{i_instruction[31]}}, i_instruction[31:25], i_instruction[11:7]};
    assign imm_b = {{19{i_instruction[31]}}, i_instruction[31], i_instruction[7],
                    i_instruction[30:25], i_instruction[11:8], 1'b0};
    assign imm_u = {i_instruction[31:12], 12'b0};
    assign imm_j = {{11{i_instruction[31]}}, i_instruction[31], i_instruction[19:12],
                    i_instruction[20], i_instruction[30:21], 1'b0};

    always_comb begin
        op      = op_nop;                           // anything unknown retires silently
        alu     = alu_add;                          // also the address adder
        cond    = br_always;
        imm     = imm_i;
        use_imm = 1'b1;
        use_a   = 1'b0;
        use_b   = 1'b0;
        case (opcode)
            OPC_OP: begin
                use_imm = 1'b0;
                use_a   = 1'b1;
                use_b   = 1'b1;
                op      = op_alu;
                case (funct3)
                    3'b000:  alu = i_instruction[30] ? alu_sub : alu_add;
                    3'b111:  alu = alu_and;
                    3'b110:  alu = alu_or;
                    3'b100:  alu = alu_xor;
                    3'b010:  alu = alu_slt;
                    default: op  = op_nop;          // shifts and sltu
                endcase
            end
            OPC_OP_IMM: begin
                use_a = 1'b1;
                if (funct3 == 3'b000)
                    op = op_alu;                    // addi
            end
            OPC_LUI: begin
                op  = op_alu;
                alu = alu_pass_b;
                imm = imm_u;
            end
            OPC_LOAD: begin
                use_a = 1'b1;
                if (funct3 == 3'b010)
                    op = op_load;
            end
            OPC_STORE: begin
                imm   = imm_s;
                use_a = 1'b1;
                use_b = 1'b1;
                if (funct3 == 3'b010)
                    op = op_store;
            end
            OPC_BRANCH: begin
                imm   = imm_b;                      // offset rides on operand b
                use_a = 1'b1;
                use_b = 1'b1;
                op    = op_branch;
                case (funct3)
                    3'b000:  cond = br_eq;
                    3'b001:  cond = br_ne;
                    default: op   = op_nop;
                endcase
            end
            OPC_JAL: begin
                op  = op_jump;
                imm = imm_j;
            end
            default: ;
        endcase
    end

    // only writers carry a destination, so r0 covers stores, branches and nops
    assign rd = (op == op_alu || op == op_load || op == op_jump) ? i_instruction[11:7] : '0;

    // read after write against execute and retire, r0 never waits
    assign raw_a = use_a && (o_reg_a != '0) &&
                   ((i_exe_valid && o_reg_a == i_exe_rd) || (i_ret_valid && o_reg_a == i_ret_rd));
    assign raw_b = use_b && (o_reg_b != '0) &&
                   ((i_exe_valid && o_reg_b == i_exe_rd) || (i_ret_valid && o_reg_b == i_ret_rd));
    // a load must not reach execute while a store holds the memory port in retire
    assign mem_hz   = (op == op_load) && i_exe_valid && (o_dx.op == op_store);
    assign o_hazard = raw_a || raw_b || mem_hz;

    always_ff @(posedge clk) begin
        if (i_reset) begin
            o_dx.valid <= 1'b0;
            o_dx.tag   <= '0;
        end else if (!i_stall) begin
            o_dx.valid <= !o_hazard;                // bubble while waiting
            o_dx.tag   <= i_tag;
        end
    end

    always_ff @(posedge clk) begin
        if (!i_stall) begin
            o_dx.npc        <= i_npc;
            o_dx.op_a       <= i_data_a;
            o_dx.op_b       <= use_imm ? imm : i_data_b;
            o_dx.store_data <= i_data_b;
            o_dx.op         <= op;
            o_dx.alu        <= alu;
            o_dx.cond       <= cond;
            o_dx.rd         <= rd;
        end
    end

endmodule

`default_nettype wire

//--- verilog/regbank.sv
/* regbank
 * 32 x XLEN register file, one clocked write and two combinational reads
 */
`timescale 1ns/100ps
`default_nettype none

module regbank import rv_pkg::*; (
    input  logic                  clk,
    input  logic                  i_we,
    input  logic [REG_ADDR_W-1:0] i_wr_addr,
    input  logic [XLEN-1:0]       i_wr_data,
    input  logic [REG_ADDR_W-1:0] i_rd_addr_a,
    input  logic [REG_ADDR_W-1:0] i_rd_addr_b,
    output logic [XLEN-1:0]       o_rd_data_a,
    output logic [XLEN-1:0]       o_rd_data_b
);

    logic [XLEN-1:0] regs [2**REG_ADDR_W];

    always_ff @(posedge clk) begin
        if (i_we && i_wr_addr != '0)                // r0 is hardwired
            regs[i_wr_addr] <= i_wr_data;
    end

    // no bypass, decode waits for the write through the hazard check
    assign o_rd_data_a = (i_rd_addr_a == '0) ? '0 : regs[i_rd_addr_a];
    assign o_rd_data_b = (i_rd_addr_b == '0) ? '0 : regs[i_rd_addr_b];

endmodule

`default_nettype wire

//--- verilog/execute.sv
/* execute
 * alu, branch compare, jump target and load address with read strobe
 */
`timescale 1ns/100ps
`default_nettype none

module execute import rv_pkg::*; (
    input  logic            clk,
    input  logic            i_reset,
    input  logic            i_stall,
    dec_exe_if.slave        i_dx,
    exe_ret_if.master       o_er,
    output logic            o_read,             // load strobe for the data memory
    output logic [XLEN-1:0] o_mem_address
);

    logic [XLEN-1:0] alu_out;
    logic            taken;

    always_comb begin
        case (i_dx.alu)
            alu_sub:    alu_out = i_dx.op_a - i_dx.op_b;
            alu_and:    alu_out = i_dx.op_a & i_dx.op_b;
            alu_or:     alu_out = i_dx.op_a | i_dx.op_b;
            alu_xor:    alu_out = i_dx.op_a ^ i_dx.op_b;
            alu_slt:    alu_out = {{(XLEN-1){1'b0}}, $signed(i_dx.op_a) < $signed(i_dx.op_b)};
            alu_pass_b: alu_out = i_dx.op_b;
            default:    alu_out = i_dx.op_a + i_dx.op_b;   // add, lw and sw address
        endcase
    end

    // branches compare against rs2, operand b holds the offset
    always_comb begin
        case (i_dx.cond)
            br_eq:   taken = (i_dx.op_a == i_dx.store_data);
            br_ne:   taken = (i_dx.op_a != i_dx.store_data);
            default: taken = 1'b1;
        endcase
    end

    // memory reads in this cycle, data comes back while the load is in retire
    assign o_read        = i_dx.valid && (i_dx.op == op_load);
    assign o_mem_address = alu_out;

    always_ff @(posedge clk) begin
        if (i_reset) begin
            o_er.valid <= 1'b0;
            o_er.tag   <= '0;
        end else if (!i_stall) begin
            o_er.valid <= i_dx.valid;
            o_er.tag   <= i_dx.tag;
        end
    end

    always_ff @(posedge clk) begin
        if (!i_stall) begin
            o_er.result     <= (i_dx.op == op_jump) ? i_dx.npc : alu_out;   // jal links
            o_er.target     <= i_dx.npc - INSTR_BYTES + i_dx.op_b;          // own pc + offset
            o_er.jump       <= (i_dx.op == op_branch || i_dx.op == op_jump) && taken;
            o_er.op         <= i_dx.op;
            o_er.rd         <= i_dx.rd;
            o_er.store_data <= i_dx.store_data;
        end
    end

endmodule

`default_nettype wire

//--- verilog/retire.sv
/* retire
 * tag check, register writeback, store issue and pc redirect
 */
`timescale 1ns/100ps
`default_nettype none

module retire import rv_pkg::*; (
    input  logic                  clk,
    input  logic                  i_reset,
    input  logic                  i_stall,
    exe_ret_if.slave              i_er,
    input  logic [XLEN-1:0]       i_data_in,        // load data, one cycle after the read
    output logic                  o_reg_we,
    output logic [REG_ADDR_W-1:0] o_wr_addr,
    output logic [XLEN-1:0]       o_wr_data,
    output logic                  o_jump,           // redirect pulse to fetch
    output logic [XLEN-1:0]       o_new_pc,
    output logic [3:0]            o_write,          // byte enables, all or nothing
    output logic [XLEN-1:0]       o_write_address,
    output logic [XLEN-1:0]       o_data_out,
    output logic [REG_ADDR_W-1:0] o_ret_rd,         // for the hazard check in decode
    output logic                  o_ret_valid
);

    tag_t exp_tag;                                  // tag of the path being committed
    logic accept;

    // wrong-path instructions still carry the tag from before the redirect
    assign accept = i_er.valid && (i_er.tag == exp_tag);

    assign o_reg_we  = accept && (i_er.op == op_alu || i_er.op == op_load ||
                                  i_er.op == op_jump);
    assign o_wr_addr = i_er.rd;
    assign o_wr_data = (i_er.op == op_load) ? i_data_in : i_er.result;

    assign o_jump   = accept && i_er.jump;
    assign o_new_pc = i_er.target;

    assign o_write         = {4{accept && (i_er.op == op_store)}};
    assign o_write_address = i_er.result;           // address from the execute adder
    assign o_data_out      = i_er.store_data;

    assign o_ret_rd    = i_er.rd;
    assign o_ret_valid = accept;

    always_ff @(posedge clk) begin
        if (i_reset)
            exp_tag <= '0;
        else if (!i_stall && o_jump)
            exp_tag <= exp_tag + 4'd1;              // same edge as the fetch tag
    end

endmodule

`default_nettype wire

//--- verilog/rv_core.sv
/* rv_core
 * four-stage rv32i subset core, connects the stages and the data port
 */
`timescale 1ns/100ps
`default_nettype none

module rv_core import rv_pkg::*; #(
    parameter logic [XLEN-1:0] RESET_PC = '0
) (
    input  logic            clk,
    input  logic            i_reset,
    input  logic            i_stall,            // holds every stage
    output logic [XLEN-1:0] o_instr_address,
    input  logic [XLEN-1:0] i_instruction,      // same-cycle instruction memory
    output logic            o_enable,
    output logic [3:0]      o_write,
    output logic [XLEN-1:0] o_data_address,
    output logic [XLEN-1:0] o_data_out,
    input  logic [XLEN-1:0] i_data_in           // registered data memory
);

    logic [XLEN-1:0]       npc, new_pc;
    tag_t                  tag;
    logic                  hazard, jump;
    logic [REG_ADDR_W-1:0] reg_a, reg_b, wr_addr, ret_rd;
    logic [XLEN-1:0]       data_a, data_b, wr_data;
    logic                  reg_we, ret_valid, mem_read;
    logic [XLEN-1:0]       read_address, write_address;

    dec_exe_if dx ();
    exe_ret_if er ();

    fetch #(.RESET_PC(RESET_PC)) fetch_i (
        .clk(clk), .i_reset(i_reset), .i_stall(i_stall),
        .i_hazard(hazard), .i_jump(jump), .i_new_pc(new_pc),
        .o_pc(o_instr_address), .o_npc(npc), .o_tag(tag)
    );

    decoder decoder_i (
        .clk(clk), .i_reset(i_reset), .i_stall(i_stall),
        .i_instruction(i_instruction), .i_npc(npc), .i_tag(tag),
        .o_reg_a(reg_a), .o_reg_b(reg_b), .i_data_a(data_a), .i_data_b(data_b),
        .i_exe_rd(dx.rd), .i_exe_valid(dx.valid),
        .i_ret_rd(ret_rd), .i_ret_valid(ret_valid),
        .o_hazard(hazard), .o_dx(dx)
    );

    regbank regbank_i (
        .clk(clk), .i_we(reg_we), .i_wr_addr(wr_addr), .i_wr_data(wr_data),
        .i_rd_addr_a(reg_a), .i_rd_addr_b(reg_b),
        .o_rd_data_a(data_a), .o_rd_data_b(data_b)
    );

    execute execute_i (
        .clk(clk), .i_reset(i_reset), .i_stall(i_stall),
        .i_dx(dx), .o_er(er), .o_read(mem_read), .o_mem_address(read_address)
    );

    retire retire_i (
        .clk(clk), .i_reset(i_reset), .i_stall(i_stall),
        .i_er(er), .i_data_in(i_data_in),
        .o_reg_we(reg_we), .o_wr_addr(wr_addr), .o_wr_data(wr_data),
        .o_jump(jump), .o_new_pc(new_pc),
        .o_write(o_write), .o_write_address(write_address), .o_data_out(o_data_out),
        .o_ret_rd(ret_rd), .o_ret_valid(ret_valid)
    );

    // single data port, a store in retire takes it over a load in execute
    always_comb begin
        if (o_write != '0)
            o_data_address = {write_address[XLEN-1:2], 2'b00};
        else
            o_data_address = {read_address[XLEN-1:2], 2'b00};  // word access only
        o_enable = (o_write != '0) || mem_read;
    end

endmodule

`default_nettype wire

//--- testbench/store_checker.sv
/* store_checker
 * watches the data port of the core and compares every store, in order,
 * against the expected store table
 */
`timescale 1ns/100ps
`default_nettype none

module store_checker #(
    parameter int NTEST = 12
) (
    input  wire logic        clk,
    input  wire logic        i_reset,
    input  wire logic        i_stall,
    input  wire logic        i_enable,
    input  wire logic [3:0]  i_write,
    input  wire logic [31:0] i_address,
    input  wire logic [31:0] i_data,
    input  wire logic [63:0] i_exp_name [NTEST],   // test names, packed text
    input  wire logic [31:0] i_exp_addr [NTEST],
    input  wire logic [31:0] i_exp_data [NTEST],
    output int               o_seen                // stores compared so far
);

    int pass_count;
    int error_count;

    initial begin
        o_seen      = 0;
        pass_count  = 0;
        error_count = 0;
    end

    // a stalled edge does not advance the pipe, so only count free edges
    always @(posedge clk) begin
        if (!i_reset && !i_stall && i_enable && i_write != 4'h0) begin
            if (i_write != 4'hf) begin
                $display("partial byte enables %h at address %h, only word stores exist",
                         i_write, i_address);
                error_count = error_count + 1;
            end else if (o_seen >= NTEST) begin
                $display("extra store of %h to address %h after the last expected store",
                         i_data, i_address);
                error_count = error_count + 1;
            end else if (i_address != i_exp_addr[o_seen]) begin
                $display("Error %0s: address expected %h actual %h",
                         i_exp_name[o_seen], i_exp_addr[o_seen], i_address);
                error_count = error_count + 1;
                o_seen = o_seen + 1;
            end else if (i_data != i_exp_data[o_seen]) begin
                $display("Error %0s: data expected %h actual %h",
                         i_exp_name[o_seen], i_exp_data[o_seen], i_data);
                error_count = error_count + 1;
                o_seen = o_seen + 1;
            end else begin
                $display("pass %0s: %h at %h", i_exp_name[o_seen], i_data, i_address);
                pass_count = pass_count + 1;
                o_seen = o_seen + 1;
            end
        end
    end

    // closing summary, called once by the testbench top
    task automatic report_summary(output int errors);
        int missing;
        missing = NTEST - o_seen;
        if (missing > 0)
            $display("%0d expected stores never arrived", missing);
        else
            missing = 0;
        $display("tests: %0d passed, %0d failed, %0d missing",
                 pass_count, error_count, missing);
        errors = error_count + missing;
    endtask

endmodule

`default_nettype wire

//--- testbench/tb_rv_core.sv
/* tb_rv_core
 * clock, reset, instruction and data memories, program and store table
 */
`timescale 1ns/100ps
`default_nettype none

module tb_rv_core;

    localparam int PROG_LEN = 33;
    localparam int NTEST    = 12;
    localparam int LIMIT    = PROG_LEN * 20;        // cycles before giving up

    localparam logic [31:0] C1 = 32'd295;
    localparam logic [31:0] C2 = -32'sd5;

    logic        clk;
    logic        i_reset;
    logic        i_stall;
    logic [31:0] o_instr_address;
    logic [31:0] i_instruction;
    logic        o_enable;
    logic [3:0]  o_write;
    logic [31:0] o_data_address;
    logic [31:0] o_data_out;
    logic [31:0] i_data_in;

    logic [31:0] prog [PROG_LEN];                   // program table
    logic [31:0] imem [64];
    logic [31:0] dmem [64];
    logic [63:0] exp_name [NTEST];                  // store table
    logic [31:0] exp_addr [NTEST];
    logic [31:0] exp_data [NTEST];

    int          seen;
    int          cycles;
    int          errors;
    integer      seed;
    logic [31:0] stall_roll;
    logic        timed_out;

    // rv32i encodings
    function automatic logic [31:0] reg_reg(input logic [6:0] f7, input logic [4:0] rs2,
                                            input logic [4:0] rs1, input logic [2:0] f3,
                                            input logic [4:0] rd);
        reg_reg = {f7, rs2, rs1, f3, rd, 7'b0110011};
    endfunction

    function automatic logic [31:0] reg_imm(input logic [11:0] imm, input logic [4:0] rs1,
                                            input logic [2:0] f3, input logic [4:0] rd,
                                            input logic [6:0] opc);
        reg_imm = {imm, rs1, f3, rd, opc};
    endfunction

    function automatic logic [31:0] store_word(input logic [11:0] imm, input logic [4:0] rs2,
                                               input logic [4:0] rs1);
        store_word = {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};
    endfunction

    function automatic logic [31:0] branch_to(input logic [12:0] imm, input logic [4:0] rs2,
                                              input logic [4:0] rs1, input logic [2:0] f3);
        branch_to = {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
    endfunction

    function automatic logic [31:0] jump_link(input logic [20:0] imm, input logic [4:0] rd);
        jump_link = {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
    endfunction

    rv_core #(.RESET_PC(32'h0)) rv_core_i (
        .clk(clk), .i_reset(i_reset), .i_stall(i_stall),
        .o_instr_address(o_instr_address), .i_instruction(i_instruction),
        .o_enable(o_enable), .o_write(o_write), .o_data_address(o_data_address),
        .o_data_out(o_data_out), .i_data_in(i_data_in)
    );

    store_checker #(.NTEST(NTEST)) store_checker_i (
        .clk(clk), .i_reset(i_reset), .i_stall(i_stall),
        .i_enable(o_enable), .i_write(o_write), .i_address(o_data_address),
        .i_data(o_data_out), .i_exp_name(exp_name), .i_exp_addr(exp_addr),
        .i_exp_data(exp_data), .o_seen(seen)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // combinational instruction memory, past the end reads as nop
    always_comb begin
        if (o_instr_address[31:8] == '0)
            i_instruction = imem[o_instr_address[7:2]];
        else
            i_instruction = 32'h0000_0013;
    end

    // one-cycle data memory, frozen by stall like the core
    always @(posedge clk) begin
        if (!i_stall && o_enable) begin
            if (o_write == 4'hf)
                dmem[o_data_address[7:2]] <= o_data_out;
            else
                i_data_in <= dmem[o_data_address[7:2]];
        end
    end

    always @(posedge clk) begin
        if (i_reset)
            cycles <= 0;
        else
            cycles <= cycles + 1;
    end

    // random stall, about one cycle in eight
    always @(posedge clk) begin
        #1;
        stall_roll = $random(seed);
        i_stall <= (stall_roll[2:0] == 3'd0);
    end

    initial begin
        seed      = 32'h7f9b;
        i_reset   = 1'b1;
        i_stall   = 1'b0;
        i_data_in = '0;
        timed_out = 1'b0;
        cycles    = 0;
        for (int i = 0; i < 64; i++)
            dmem[i] = {16'hd0d0, 8'h00, i[5:0], 2'b00};

        prog[0]  = reg_imm(C1[11:0], 5'd0, 3'b000, 5'd1, 7'b0010011);
        prog[1]  = reg_imm(C2[11:0], 5'd0, 3'b000, 5'd2, 7'b0010011);
        prog[2]  = reg_reg(7'h00, 5'd2, 5'd1, 3'b000, 5'd3);           // add
        prog[3]  = store_word(12'h040, 5'd3, 5'd0);
        prog[4]  = reg_reg(7'h20, 5'd2, 5'd1, 3'b000, 5'd4);           // sub
        prog[5]  = store_word(12'h044, 5'd4, 5'd0);
        prog[6]  = reg_reg(7'h00, 5'd2, 5'd1, 3'b111, 5'd5);           // and
        prog[7]  = store_word(12'h048, 5'd5, 5'd0);
        prog[8]  = reg_reg(7'h00, 5'd2, 5'd1, 3'b110, 5'd6);           // or
        prog[9]  = store_word(12'h04c, 5'd6, 5'd0);
        prog[10] = reg_reg(7'h00, 5'd2, 5'd1, 3'b100, 5'd7);           // xor
        prog[11] = store_word(12'h050, 5'd7, 5'd0);
        prog[12] = reg_reg(7'h00, 5'd1, 5'd2, 3'b010, 5'd8);           // slt x8, x2, x1
        prog[13] = store_word(12'h054, 5'd8, 5'd0);
        prog[14] = store_word(12'h058, 5'd1, 5'd0);
        prog[15] = reg_imm(12'd7, 5'd1, 3'b000, 5'd9, 7'b0010011);     // dependent chain
        prog[16] = reg_reg(7'h00, 5'd9, 5'd9, 3'b000, 5'd9);
        prog[17] = reg_reg(7'h20, 5'd2, 5'd9, 3'b000, 5'd9);
        prog[18] = store_word(12'h05c, 5'd9, 5'd0);
        prog[19] = {20'h12345, 5'd11, 7'b0110111};                     // lui
        prog[20] = store_word(12'h060, 5'd11, 5'd0);
        prog[21] = reg_imm(12'h060, 5'd0, 3'b010, 5'd12, 7'b0000011);  // lw
        prog[22] = reg_imm(12'd1, 5'd12, 3'b000, 5'd12, 7'b0010011);
        prog[23] = store_word(12'h064, 5'd12, 5'd0);
        prog[24] = branch_to(13'd12, 5'd1, 5'd1, 3'b000);              // beq taken
        prog[25] = store_word(12'h068, 5'd2, 5'd0);                    // marker, skipped
        prog[26] = store_word(12'h068, 5'd2, 5'd0);                    // marker, skipped
        prog[27] = branch_to(13'd8, 5'd1, 5'd1, 3'b001);               // bne not taken
        prog[28] = store_word(12'h068, 5'd1, 5'd0);
        prog[29] = jump_link(21'd8, 5'd13);                            // link is 120
        prog[30] = store_word(12'h06c, 5'd2, 5'd0);                    // marker, skipped
        prog[31] = store_word(12'h06c, 5'd13, 5'd0);
        prog[32] = jump_link(21'd0, 5'd0);                             // park here

        for (int i = 0; i < 64; i++)
            imem[i] = (i < PROG_LEN) ? prog[i] : 32'h0000_0013;

        exp_name[0]  = "add";     exp_addr[0]  = 32'h40; exp_data[0]  = C1 + C2;
        exp_name[1]  = "sub";     exp_addr[1]  = 32'h44; exp_data[1]  = C1 - C2;
        exp_name[2]  = "and";     exp_addr[2]  = 32'h48; exp_data[2]  = C1 & C2;
        exp_name[3]  = "or";      exp_addr[3]  = 32'h4c; exp_data[3]  = C1 | C2;
        exp_name[4]  = "xor";     exp_addr[4]  = 32'h50; exp_data[4]  = C1 ^ C2;
        exp_name[5]  = "slt";     exp_addr[5]  = 32'h54;
        exp_data[5]  = ($signed(C2) < $signed(C1)) ? 32'd1 : 32'd0;
        exp_name[6]  = "addi";    exp_addr[6]  = 32'h58; exp_data[6]  = C1;
        exp_name[7]  = "chain";   exp_addr[7]  = 32'h5c; exp_data[7]  = (C1 + 7) * 2 - C2;
        exp_name[8]  = "lui";     exp_addr[8]  = 32'h60; exp_data[8]  = 32'h1234_5000;
        exp_name[9]  = "load";    exp_addr[9]  = 32'h64; exp_data[9]  = 32'h1234_5001;
        exp_name[10] = "branch";  exp_addr[10] = 32'h68; exp_data[10] = C1;
        exp_name[11] = "jal";     exp_addr[11] = 32'h6c; exp_data[11] = 32'd120;

        repeat (16) @(posedge clk);
        #1 i_reset = 1'b0;

        // run until every expected store is seen or the limit is hit
        while (seen < NTEST && cycles < LIMIT)
            @(posedge clk);
        if (seen < NTEST) begin
            timed_out = 1'b1;
            $display("timeout after %0d cycles with %0d of %0d stores seen",
                     cycles, seen, NTEST);
        end
        repeat (20) @(posedge clk);                 // window for stray stores

        store_checker_i.report_summary(errors);
        if (errors == 0 && !timed_out) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- sources.f
verilog/rv_pkg.sv
verilog/pipe_if.sv
verilog/fetch.sv
verilog/decoder.sv
verilog/regbank.sv
verilog/execute.sv
verilog/retire.sv
verilog/rv_core.sv
testbench/store_checker.sv
testbench/tb_rv_core.sv

//--- run.sh
#!/bin/bash
# build and run the rv_core testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f sources.f --top-module tb_rv_core -o sim_tb_rv_core
./obj_dir/sim_tb_rv_core > sim.log 2>&1 || true
cat sim.log

if grep -q "ERRORS FOUND" sim.log; then
    exit 1
fi
if ! grep -q "NO ERRORS" sim.log; then
    exit 1
fi
exit 0
